// File: hdl/frame_match_pkg.sv
package frame_match_pkg;

	// stream and pattern memory
	typedef logic [7:0] byte_t;
	typedef logic [29:0] pattern_word_t;
	typedef logic [10:0] mem_addr_t;

	// host bus
	typedef logic [11:0] wb_addr_t;
	typedef logic [31:0] wb_data_t;

	// match results
	typedef logic [2:0] match_vec_t;
	typedef logic [1:0] match_id_t;
	typedef logic [15:0] hit_count_t;

	localparam int N_PATTERNS = 3;

	// per pattern i the flags sit at DONT_CARE_BASE + 2i and END_BASE + 2i
	localparam int DONT_CARE_BASE = 24;
	localparam int END_BASE = 25;

	// host addresses below this one go to the pattern memory
	localparam wb_addr_t MEM_SPACE_SIZE = 12'h800;

	localparam wb_addr_t CSR_MATCH_EN = 12'h800;
	localparam wb_addr_t CSR_HITS_BASE = 12'h801;
	localparam wb_addr_t CSR_STATUS = 12'h804;

	// match_id sits in bits 5:4 of the status word
	localparam int STATUS_ID_LSB = 4;

	typedef enum logic {
		idle,
		host_wait_ack
	} arb_state_t;

endpackage

// File: hdl/pattern_ram.sv
module pattern_ram #(
	parameter int MEM_ADDR_W = 11
) (
	input logic s_axis_clk,

	input logic en,
	input logic we,
	input frame_match_pkg::mem_addr_t addr,
	input frame_match_pkg::pattern_word_t wdata,
	output frame_match_pkg::pattern_word_t rdata
);
	import frame_match_pkg::*;

	localparam int DEPTH = 2 ** MEM_ADDR_W;

	// inferred block RAM, one word per beat position
	pattern_word_t mem [DEPTH];

	logic [MEM_ADDR_W-1:0] word_idx;

	// only the low address bits select a word in a smaller memory
	assign word_idx = addr[MEM_ADDR_W-1:0];

	// read before write, the read data is registered
	always_ff @(posedge s_axis_clk) begin
		if (en) begin
			if (we) begin
				mem[word_idx] <= wdata;
			end
			rdata <= mem[word_idx];
		end
	end

endmodule

// File: hdl/pattern_mem_arbiter.sv
module pattern_mem_arbiter #(
	parameter int MEM_ADDR_W = 11
) (
	input logic s_axis_clk,
	input logic rst_n_cdc,

	// matcher side, read only
	input logic stream_rd,
	input frame_match_pkg::mem_addr_t stream_addr,
	output frame_match_pkg::pattern_word_t stream_data,

	// host side, Wishbone classic slave
	input logic mem_cyc,
	input logic mem_stb,
	input logic mem_we,
	input frame_match_pkg::mem_addr_t mem_adr,
	input frame_match_pkg::pattern_word_t mem_dat_w,
	output frame_match_pkg::wb_data_t mem_dat_r,
	output logic mem_ack,

	// RAM port
	output logic ram_en,
	output logic ram_we,
	output frame_match_pkg::mem_addr_t ram_addr,
	output frame_match_pkg::pattern_word_t ram_wdata,
	input frame_match_pkg::pattern_word_t ram_rdata
);
	import frame_match_pkg::*;

	arb_state_t state;

	logic host_req;
	logic host_grant;
	logic [MEM_ADDR_W-1:0] sel_addr;

	assign host_req = mem_cyc & mem_stb;

	// the stream has no back-pressure, so the host only gets cycles without a beat
	assign host_grant = (state == idle) & host_req & ~stream_rd;

	assign sel_addr = stream_rd ? stream_addr[MEM_ADDR_W-1:0] : mem_adr[MEM_ADDR_W-1:0];

	assign ram_en = stream_rd | host_grant;
	assign ram_we = host_grant & mem_we;
	assign ram_addr = mem_addr_t'(sel_addr);
	assign ram_wdata = mem_dat_w;

	// both requesters look at the same read port
	assign stream_data = ram_rdata;
	assign mem_dat_r = wb_data_t'(ram_rdata);

	// the host word was read at the grant edge and is valid now,
	// even if a beat is taking the port in this cycle
	assign mem_ack = (state == host_wait_ack);

	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (host_grant) begin
						state <= host_wait_ack;
					end
				end
				host_wait_ack: begin
					state <= idle;
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// an acked host write went into the RAM in a cycle that had no beat
	assert property (@(posedge s_axis_clk) disable iff (!rst_n_cdc)
		(mem_ack && mem_we) |-> $past(ram_we && !stream_rd));

	// the host is only answered while its cycle is still open
	assert property (@(posedge s_axis_clk) disable iff (!rst_n_cdc)
		mem_ack |-> mem_cyc);

endmodule

// File: hdl/eth_frame_matcher.sv
module eth_frame_matcher #(
	parameter int MEM_ADDR_W = 11
) (
	input logic s_axis_clk,
	input logic rst_n_cdc,

	input frame_match_pkg::byte_t s_axis_tdata,
	input logic s_axis_tlast,
	input logic s_axis_tvalid,

	input frame_match_pkg::match_vec_t match_en,

	// pattern memory read, data comes back one cycle after the beat
	output logic stream_rd,
	output frame_match_pkg::mem_addr_t stream_addr,
	input frame_match_pkg::pattern_word_t stream_data,

	output frame_match_pkg::match_vec_t match,
	output frame_match_pkg::match_id_t match_id,
	output logic frame_done
);
	import frame_match_pkg::*;

	logic [MEM_ADDR_W-1:0] beat_cnt;

	// beat registered to line up with the RAM data
	byte_t axis_data_q;
	logic axis_last_q;
	logic axis_valid_q;

	// all beats of the current frame agreed so far
	match_vec_t pattern_agree;
	match_vec_t beat_miss;
	match_vec_t frame_match;

	logic frame_end;

	assign stream_rd = s_axis_tvalid;
	assign stream_addr = mem_addr_t'(beat_cnt);

	// position of the current beat within its frame
	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc) begin
			beat_cnt <= '0;
		end else if (s_axis_tvalid) begin
			if (s_axis_tlast) begin
				beat_cnt <= '0;
			end else begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge s_axis_clk) begin
		axis_data_q <= s_axis_tdata;
		axis_last_q <= s_axis_tlast;
	end

	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc) begin
			axis_valid_q <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			axis_valid_q <= s_axis_tvalid;
			frame_end <= axis_valid_q & axis_last_q;
		end
	end

	for (genvar i = 0; i < N_PATTERNS; i++) begin : g_pattern
		// a wrong byte counts unless it is a don't-care place, and an end
		// mark before the real end of the frame always fails
		assign beat_miss[i] =
			(stream_data[8*i +: 8] != axis_data_q && !stream_data[DONT_CARE_BASE + 2*i])
			|| (stream_data[END_BASE + 2*i] && !axis_last_q);

		always_ff @(posedge s_axis_clk) begin
			if (!rst_n_cdc) begin
				pattern_agree[i] <= 1'b1;
				frame_match[i] <= 1'b0;
			end else if (axis_valid_q) begin
				if (axis_last_q) begin
					frame_match[i] <= pattern_agree[i] & ~beat_miss[i] & match_en[i];
					pattern_agree[i] <= 1'b1;
				end else if (beat_miss[i]) begin
					pattern_agree[i] <= 1'b0;
				end
			end
		end
	end

	// counts frames that hit any pattern, wrapping at four
	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc) begin
			match_id <= '0;
		end else if (frame_end && frame_match != '0) begin
			match_id <= match_id + 1'b1;
		end
	end

	assign match = frame_match;
	assign frame_done = frame_end;

	// a frame longer than the pattern memory would alias onto its first words
	assert property (@(posedge s_axis_clk) disable iff (!rst_n_cdc)
		(s_axis_tvalid && !s_axis_tlast) |-> (beat_cnt != '1));

endmodule

// File: hdl/matcher_csr.sv
module matcher_csr (
	input logic s_axis_clk,
	input logic rst_n_cdc,

	// host Wishbone classic slave
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input frame_match_pkg::wb_addr_t wb_adr,
	input frame_match_pkg::wb_data_t wb_dat_w,
	output frame_match_pkg::wb_data_t wb_dat_r,
	output logic wb_ack,

	// forwarded pattern memory access
	output logic mem_cyc,
	output logic mem_stb,
	output logic mem_we,
	output frame_match_pkg::mem_addr_t mem_adr,
	output frame_match_pkg::pattern_word_t mem_dat_w,
	input frame_match_pkg::wb_data_t mem_dat_r,
	input logic mem_ack,

	output frame_match_pkg::match_vec_t match_en,
	input frame_match_pkg::match_vec_t match,
	input frame_match_pkg::match_id_t match_id,
	input logic frame_done
);
	import frame_match_pkg::*;

	logic mem_sel;
	logic reg_access;
	logic reg_ack;

	wb_data_t reg_rdata;
	wb_data_t reg_rdata_q;

	hit_count_t hit_cnt [N_PATTERNS];

	assign mem_sel = (wb_adr < MEM_SPACE_SIZE);

	// pattern memory accesses go straight through to the arbiter
	assign mem_cyc = wb_cyc & mem_sel;
	assign mem_stb = wb_stb & mem_sel;
	assign mem_we = wb_we;
	assign mem_adr = wb_adr[10:0];
	assign mem_dat_w = wb_dat_w[29:0];

	// first cycle of a register access, the ack follows one cycle later
	assign reg_access = wb_cyc & wb_stb & ~mem_sel & ~reg_ack;

	always_comb begin
		reg_rdata = '0;
		if (wb_adr == CSR_MATCH_EN) begin
			reg_rdata = wb_data_t'(match_en);
		end else if (wb_adr == CSR_STATUS) begin
			reg_rdata = wb_data_t'(match);
			reg_rdata[STATUS_ID_LSB +: 2] = match_id;
		end
		for (int i = 0; i < N_PATTERNS; i++) begin
			if (wb_adr == CSR_HITS_BASE + wb_addr_t'(i)) begin
				reg_rdata = wb_data_t'(hit_cnt[i]);
			end
		end
	end

	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc) begin
			reg_ack <= 1'b0;
			match_en <= '0;
		end else begin
			reg_ack <= reg_access;
			// the other registers are read only, so writes to them are dropped
			if (reg_access && wb_we && wb_adr == CSR_MATCH_EN) begin
				match_en <= wb_dat_w[2:0];
			end
		end
	end

	always_ff @(posedge s_axis_clk) begin
		if (reg_access) begin
			reg_rdata_q <= reg_rdata;
		end
	end

	// hit counters stop at their maximum
	always_ff @(posedge s_axis_clk) begin
		for (int i = 0; i < N_PATTERNS; i++) begin
			if (!rst_n_cdc) begin
				hit_cnt[i] <= '0;
			end else if (frame_done && match[i] && hit_cnt[i] != '1) begin
				hit_cnt[i] <= hit_cnt[i] + 1'b1;
			end
		end
	end

	assign wb_ack = reg_ack | mem_ack;
	assign wb_dat_r = reg_ack ? reg_rdata_q : mem_dat_r;

	// each access gets exactly one ack cycle, on either path
	assert property (@(posedge s_axis_clk) disable iff (!rst_n_cdc)
		wb_ack |=> !wb_ack);

endmodule

// File: hdl/frame_match_top.sv
module frame_match_top (
	input logic s_axis_clk,
	input logic rst_n_cdc,

	// received frames, one byte per beat
	input frame_match_pkg::byte_t s_axis_tdata,
	input logic s_axis_tuser,
	input logic s_axis_tlast,
	input logic s_axis_tvalid,

	// host port
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input frame_match_pkg::wb_addr_t wb_adr,
	input frame_match_pkg::wb_data_t wb_dat_w,
	output frame_match_pkg::wb_data_t wb_dat_r,
	output logic wb_ack,

	output frame_match_pkg::match_vec_t match,
	output frame_match_pkg::match_id_t match_id
);
	import frame_match_pkg::*;

	localparam int MEM_ADDR_W = 11;

	match_vec_t match_en;
	logic frame_done;

	logic mem_cyc;
	logic mem_stb;
	logic mem_we;
	mem_addr_t mem_adr;
	pattern_word_t mem_dat_w;
	wb_data_t mem_dat_r;
	logic mem_ack;

	logic stream_rd;
	mem_addr_t stream_addr;
	pattern_word_t stream_data;

	logic ram_en;
	logic ram_we;
	mem_addr_t ram_addr;
	pattern_word_t ram_wdata;
	pattern_word_t ram_rdata;

	// s_axis_tuser carries no information for matching and stays unused

	matcher_csr matcher_csr_i (
		.s_axis_clk(s_axis_clk),
		.rst_n_cdc(rst_n_cdc),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.mem_cyc(mem_cyc),
		.mem_stb(mem_stb),
		.mem_we(mem_we),
		.mem_adr(mem_adr),
		.mem_dat_w(mem_dat_w),
		.mem_dat_r(mem_dat_r),
		.mem_ack(mem_ack),
		.match_en(match_en),
		.match(match),
		.match_id(match_id),
		.frame_done(frame_done)
	);

	pattern_mem_arbiter #(.MEM_ADDR_W(MEM_ADDR_W)) pattern_mem_arbiter_i (
		.s_axis_clk(s_axis_clk),
		.rst_n_cdc(rst_n_cdc),
		.stream_rd(stream_rd),
		.stream_addr(stream_addr),
		.stream_data(stream_data),
		.mem_cyc(mem_cyc),
		.mem_stb(mem_stb),
		.mem_we(mem_we),
		.mem_adr(mem_adr),
		.mem_dat_w(mem_dat_w),
		.mem_dat_r(mem_dat_r),
		.mem_ack(mem_ack),
		.ram_en(ram_en),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata)
	);

	pattern_ram #(.MEM_ADDR_W(MEM_ADDR_W)) pattern_ram_i (
		.s_axis_clk(s_axis_clk),
		.en(ram_en),
		.we(ram_we),
		.addr(ram_addr),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

	eth_frame_matcher #(.MEM_ADDR_W(MEM_ADDR_W)) eth_frame_matcher_i (
		.s_axis_clk(s_axis_clk),
		.rst_n_cdc(rst_n_cdc),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tlast(s_axis_tlast),
		.s_axis_tvalid(s_axis_tvalid),
		.match_en(match_en),
		.stream_rd(stream_rd),
		.stream_addr(stream_addr),
		.stream_data(stream_data),
		.match(match),
		.match_id(match_id),
		.frame_done(frame_done)
	);

endmodule

// File: verification/tb_checker.sv
module tb_checker (
	input logic s_axis_clk,
	input logic rst_n_cdc,
	input frame_match_pkg::byte_t s_axis_tdata,
	input logic s_axis_tlast,
	input logic s_axis_tvalid,
	input logic wb_we,
	input frame_match_pkg::wb_addr_t wb_adr,
	input frame_match_pkg::wb_data_t wb_dat_w,
	input frame_match_pkg::wb_data_t wb_dat_r,
	input logic wb_ack,
	input frame_match_pkg::match_vec_t match,
	input frame_match_pkg::match_id_t match_id,
	output int check_count,
	output int error_count
);
	import frame_match_pkg::*;

	int n_checks = 0;
	int n_errors = 0;

	// model of the pattern memory, built from the host writes seen on the bus
	pattern_word_t model_mem [2048];
	logic [2047:0] written = '0;
	match_vec_t model_en = '0;
	match_vec_t last_match = '0;
	match_id_t model_id = '0;
	hit_count_t hits [N_PATTERNS];

	// inputs are sampled on the rising edge, where they are stable
	logic rst_q = 1'b1;
	logic we_q;
	wb_addr_t adr_q;
	wb_data_t dat_w_q;

	byte_t frame_buf [64];
	int frame_len = 0;

	// frame results delayed to the cycles where the DUT shows them
	logic d1;
	logic d2;
	logic d3;
	match_vec_t agree_d1;
	match_vec_t exp_d2;
	match_vec_t exp_d3;

	assign check_count = n_checks;
	assign error_count = n_errors;

	// a frame agrees with a pattern when no beat has a wrong byte at a place that
	// is not don't-care, and no end mark shows up before the last beat
	function automatic match_vec_t frame_agreement(input int len);
		match_vec_t agree;
		pattern_word_t w;
		logic miss;
		agree = '1;
		for (int k = 0; k < len; k++) begin
			w = model_mem[k];
			for (int i = 0; i < N_PATTERNS; i++) begin
				miss = (frame_buf[k] != w[8*i +: 8] && !w[DONT_CARE_BASE + 2*i])
					|| (w[END_BASE + 2*i] && k != len - 1);
				if (miss) begin
					agree[i] = 1'b0;
				end
			end
		end
		return agree;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	// one completed host access, with address and data from the grant edge
	task automatic check_bus();
		if (adr_q < MEM_SPACE_SIZE) begin
			if (we_q) begin
				model_mem[adr_q[10:0]] = dat_w_q[29:0];
				written[adr_q[10:0]] = 1'b1;
			end else if (written[adr_q[10:0]]) begin
				compare_value("wb_dat_r", 32'(model_mem[adr_q[10:0]]), wb_dat_r);
			end
		end else if (we_q) begin
			if (adr_q == CSR_MATCH_EN) begin
				model_en = dat_w_q[2:0];
			end
		end else if (adr_q == CSR_MATCH_EN) begin
			compare_value("wb_dat_r", 32'(model_en), wb_dat_r);
		end else if (adr_q == CSR_STATUS) begin
			compare_value("wb_dat_r", {26'b0, model_id, 1'b0, last_match}, wb_dat_r);
		end else if (adr_q >= CSR_HITS_BASE && adr_q < CSR_STATUS) begin
			compare_value("wb_dat_r", 32'(hits[int'(adr_q - CSR_HITS_BASE)]), wb_dat_r);
		end
	endtask

	always @(posedge s_axis_clk) begin
		logic done_now;
		match_vec_t agree_now;
		done_now = 1'b0;
		agree_now = '0;
		rst_q <= rst_n_cdc;
		we_q <= wb_we;
		adr_q <= wb_adr;
		dat_w_q <= wb_dat_w;
		if (!rst_n_cdc) begin
			frame_len = 0;
			d1 <= 1'b0;
			d2 <= 1'b0;
			d3 <= 1'b0;
		end else begin
			if (s_axis_tvalid && frame_len < 64) begin
				frame_buf[frame_len] = s_axis_tdata;
				frame_len++;
				if (s_axis_tlast) begin
					agree_now = frame_agreement(frame_len);
					done_now = 1'b1;
					frame_len = 0;
				end
			end
			d1 <= done_now;
			agree_d1 <= agree_now;
			// the enable mask is taken one cycle after the last beat
			d2 <= d1;
			exp_d2 <= agree_d1 & model_en;
			d3 <= d2;
			exp_d3 <= exp_d2;
		end
	end

	// outputs are compared on the falling edge, half a cycle after they change
	always @(negedge s_axis_clk) begin
		if (!rst_q) begin
			model_en = '0;
			model_id = '0;
			last_match = '0;
			for (int i = 0; i < N_PATTERNS; i++) begin
				hits[i] = '0;
			end
			compare_value("match", 32'd0, 32'(match));
			compare_value("match_id", 32'd0, 32'(match_id));
			compare_value("wb_ack", 32'd0, 32'(wb_ack));
		end else begin
			if (d2) begin
				last_match = exp_d2;
				compare_value("match", 32'(exp_d2), 32'(match));
			end
			if (d3) begin
				if (exp_d3 != '0) begin
					model_id = model_id + 2'd1;
				end
				for (int i = 0; i < N_PATTERNS; i++) begin
					if (exp_d3[i] && hits[i] != 16'hffff) begin
						hits[i] = hits[i] + 16'd1;
					end
				end
				compare_value("match_id", 32'(model_id), 32'(match_id));
			end
			if (wb_ack) begin
				check_bus();
			end
		end
	end

endmodule

// File: verification/tb_frame_matcher.sv
module tb_frame_matcher;
	import frame_match_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int MAX_FRAME_LEN = 24;
	localparam int MAX_GAP = 3;
	localparam int N_MATCH_FRAMES = 40;
	localparam int N_MASK_ROUNDS = 5;
	localparam int FRAMES_PER_ROUND = 8;
	localparam int N_FRAMES = N_MATCH_FRAMES + N_MASK_ROUNDS * FRAMES_PER_ROUND;
	localparam int N_HOST = 3 * MAX_FRAME_LEN + 2 * N_MASK_ROUNDS + 16;
	// every frame at its longest with the widest gaps, each host access a few cycles
	localparam longint TIMEOUT = longint'(N_FRAMES * MAX_FRAME_LEN * (MAX_GAP + 1)
		+ N_HOST * 4 + 500) * CLK_PERIOD;

	logic s_axis_clk;
	logic rst_n_cdc;
	byte_t s_axis_tdata;
	logic s_axis_tuser;
	logic s_axis_tlast;
	logic s_axis_tvalid;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_addr_t wb_adr;
	wb_data_t wb_dat_w;
	wb_data_t wb_dat_r;
	logic wb_ack;
	match_vec_t match;
	match_id_t match_id;

	int check_count;
	int error_count;
	int test_num = 1;
	int checks_before = 0;
	int errors_before = 0;

	logic [15:0] lfsr_state = 16'd57;
	pattern_word_t pat_words [MAX_FRAME_LEN];
	int pat_len [N_PATTERNS];

	frame_match_top frame_match_top_i (.*);

	tb_checker checker_i (.*);

	initial begin
		s_axis_clk = 1'b0;
		forever #(CLK_PERIOD / 2) s_axis_clk = ~s_axis_clk;
	end

	initial begin
		#(TIMEOUT);
		$display("watchdog expired at %0t, the tests did not finish in time", $time);
		$display("Simulation FAILED");
		$finish;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	// one LFSR step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int b = 0; b < n; b++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	// Wishbone classic access, ack is seen on a falling edge and the
	// signals stay up through the rising edge that closes the ack cycle
	task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = data;
		@(negedge s_axis_clk);
		while (!wb_ack) @(negedge s_axis_clk);
		@(negedge s_axis_clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic load_patterns();
		pattern_word_t w;
		for (int i = 0; i < N_PATTERNS; i++) begin
			pat_len[i] = 4 + int'(rand_bits(5)) % 17;
		end
		// words past a pattern's end still get bytes, longer frames read them
		for (int k = 0; k < MAX_FRAME_LEN; k++) begin
			w = '0;
			for (int i = 0; i < N_PATTERNS; i++) begin
				w[8*i +: 8] = 8'(rand_bits(8));
				w[DONT_CARE_BASE + 2*i] = (rand_bits(2) == 32'd3);
				w[END_BASE + 2*i] = (k == pat_len[i] - 1);
			end
			pat_words[k] = w;
			bus_access(1'b1, wb_addr_t'(k), 32'(w));
		end
	endtask

	task automatic read_back_words();
		for (int k = 0; k < MAX_FRAME_LEN; k++) begin
			bus_access(1'b0, wb_addr_t'(k), '0);
		end
	endtask

	// an exact copy, a copy with one byte changed, or a copy of another length
	task automatic send_frame();
		byte_t bytes [MAX_FRAME_LEN];
		int p;
		int kind;
		int len;
		int pos;
		p = int'(rand_bits(2)) % N_PATTERNS;
		kind = int'(rand_bits(2));
		len = pat_len[p];
		if (kind == 3) begin
			len = 1 + int'(rand_bits(5)) % MAX_FRAME_LEN;
		end
		for (int k = 0; k < len; k++) begin
			bytes[k] = pat_words[k][8*p +: 8];
			if (pat_words[k][DONT_CARE_BASE + 2*p]) begin
				bytes[k] = 8'(rand_bits(8));
			end
		end
		if (kind == 2) begin
			pos = int'(rand_bits(5)) % len;
			bytes[pos] = bytes[pos] ^ (8'(rand_bits(8)) | 8'h01);
		end
		for (int k = 0; k < len; k++) begin
			repeat (int'(rand_bits(2))) @(negedge s_axis_clk);
			s_axis_tvalid = 1'b1;
			s_axis_tdata = bytes[k];
			s_axis_tlast = (k == len - 1);
			s_axis_tuser = rand_bits(1) != 32'd0;
			@(negedge s_axis_clk);
			s_axis_tvalid = 1'b0;
			s_axis_tlast = 1'b0;
		end
	endtask

	task automatic report_test(input string name);
		// let the results of the last frame reach the checker
		repeat (4) @(negedge s_axis_clk);
		$display("test %0d %s: %0d checks, %0d errors", test_num, name,
			check_count - checks_before, error_count - errors_before);
		test_num++;
		checks_before = check_count;
		errors_before = error_count;
	endtask

	initial begin
		rst_n_cdc = 1'b0;
		s_axis_tdata = '0;
		s_axis_tuser = 1'b0;
		s_axis_tlast = 1'b0;
		s_axis_tvalid = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (2) @(negedge s_axis_clk);
		rst_n_cdc = 1'b1;

		for (int a = 0; a < 5; a++) begin
			bus_access(1'b0, CSR_MATCH_EN + wb_addr_t'(a), '0);
		end
		report_test("reset values");

		load_patterns();
		read_back_words();
		report_test("pattern memory read-back");

		// host reads run alongside the stream and have to wait for free cycles
		bus_access(1'b1, CSR_MATCH_EN, 32'h7);
		fork
			begin
				for (int f = 0; f < N_MATCH_FRAMES; f++) begin
					send_frame();
				end
			end
			read_back_words();
		join
		report_test("frame matching");

		for (int r = 0; r < N_MASK_ROUNDS; r++) begin
			bus_access(1'b1, CSR_MATCH_EN, rand_bits(3));
			bus_access(1'b0, CSR_MATCH_EN, '0);
			for (int f = 0; f < FRAMES_PER_ROUND; f++) begin
				send_frame();
			end
		end
		report_test("enable masking");

		// the counter register is read only, so this write leaves it unchanged
		bus_access(1'b1, CSR_HITS_BASE, rand_bits(16));
		for (int a = 1; a < 5; a++) begin
			bus_access(1'b0, CSR_MATCH_EN + wb_addr_t'(a), '0);
		end
		report_test("hit counters and status");

		$display("%0d tests, %0d checks, %0d errors", test_num - 1, check_count, error_count);
		if (error_count == 0 && check_count > 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: src.f
hdl/frame_match_pkg.sv
hdl/pattern_ram.sv
hdl/pattern_mem_arbiter.sv
hdl/eth_frame_matcher.sv
hdl/matcher_csr.sv
hdl/frame_match_top.sv
verification/tb_checker.sv
verification/tb_frame_matcher.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log for the pass line

set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_frame_matcher -f src.f \
	&& ./obj_dir/Vtb_frame_matcher 2>&1 | tee sim.log \
	|| { echo "build or run did not complete"; exit 1; }

grep -qx "Simulation PASSED" sim.log \
	&& echo "run_sim: log shows a passing run" \
	|| { echo "run_sim: no passing result in sim.log"; exit 1; }
